// File: logic/pix_pkg.sv
/*
 * shared widths and beat layout for the sensor reorder path
 * credit and output buffer sizes, framer state encoding
 */

package pix_pkg;

	// ------------------------------
	// pixel and beat layout
	// ------------------------------

	// one pixel per channel
	localparam int PIX_W = 10;
	// sensor channels, lane 0 in the low bits
	localparam int LANES = 4;
	localparam int BEAT_W = LANES * PIX_W;
	// two kernels of eight pixels span four beats
	localparam int GROUP_BEATS = 4;

	// ------------------------------
	// downstream link
	// ------------------------------

	// credits granted by the receiver at reset
	localparam int CREDIT_MAX = 8;
	// counter must hold CREDIT_MAX itself
	localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

	// output FIFO, power of two so the pointers wrap
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

	// ------------------------------
	// framer states
	// ------------------------------

	// idle = outside frame, line = active pixels, gap = between lines
	typedef enum logic [1:0] {
		FR_IDLE,
		FR_LINE,
		FR_GAP
	} framer_state_t;

endpackage

// File: logic/kernel_reorder.sv
/*
 * kernel reorder for the four-channel sensor
 * restores linear pixel order from the mirrored kernel layout
 */
`timescale 1ns/1ns

module kernel_reorder (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_fval,
	input  logic                         i_lval,
	input  logic [pix_pkg::BEAT_W-1:0]   i_pix_data,
	output logic                         o_fval,
	output logic                         o_lval,
	output logic [pix_pkg::BEAT_W-1:0]   o_pix_data
);

	logic                                         beat_valid;
	logic [$clog2(pix_pkg::GROUP_BEATS)-1:0]      beat_cnt;
	logic                                         cnt_dly0;
	logic                                         cnt_dly1;
	logic                                         cnt_dly2;
	logic [pix_pkg::PIX_W-1:0]                    lane  [pix_pkg::LANES];
	logic [pix_pkg::PIX_W-1:0]                    bank0 [pix_pkg::LANES];
	logic [pix_pkg::PIX_W-1:0]                    bank1 [pix_pkg::LANES];
	logic [pix_pkg::BEAT_W-1:0]                   bank0_flat;
	logic [pix_pkg::BEAT_W-1:0]                   bank1_flat;
	logic [pix_pkg::BEAT_W-1:0]                   latch0;
	logic [pix_pkg::BEAT_W-1:0]                   latch1;
	logic [pix_pkg::BEAT_W-1:0]                   dout;
	logic [3:0]                                   fval_sr;
	logic [3:0]                                   lval_sr;

	assign beat_valid = i_fval & i_lval;

	// ------------------------------
	// beat counter within a group
	// ------------------------------
	always_ff @(posedge clk) begin
		if (i_reset || !beat_valid) begin
			beat_cnt <= '0;
		end else begin
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

	// select for the output mux, three cycles behind
	always_ff @(posedge clk) begin
		if (i_reset) begin
			cnt_dly0 <= 1'b0;
			cnt_dly1 <= 1'b0;
			cnt_dly2 <= 1'b0;
		end else begin
			cnt_dly0 <= beat_cnt[0];
			cnt_dly1 <= cnt_dly0;
			cnt_dly2 <= cnt_dly1;
		end
	end

	// split beat and rebuild banks, lane 0 lowest
	for (genvar i = 0; i < pix_pkg::LANES; i++) begin : g_lane
		assign lane[i] = i_pix_data[i*pix_pkg::PIX_W +: pix_pkg::PIX_W];
		assign bank0_flat[i*pix_pkg::PIX_W +: pix_pkg::PIX_W] = bank0[i];
		assign bank1_flat[i*pix_pkg::PIX_W +: pix_pkg::PIX_W] = bank1[i];
	end

	// ------------------------------
	// steering into staging banks
	// ------------------------------
	// beats 0,1: even kernel, even pixels to bank0, odd to bank1
	// beats 2,3: odd kernel, channel order mirrored
	always_ff @(posedge clk) begin
		if (beat_valid) begin
			case (beat_cnt)
				2'd0: begin
					bank0[0] <= lane[0];
					bank1[0] <= lane[1];
					bank0[1] <= lane[2];
					bank1[1] <= lane[3];
				end
				2'd1: begin
					bank0[2] <= lane[0];
					bank1[2] <= lane[1];
					bank0[3] <= lane[2];
					bank1[3] <= lane[3];
				end
				2'd2: begin
					bank1[3] <= lane[0];
					bank0[3] <= lane[1];
					bank1[2] <= lane[2];
					bank0[2] <= lane[3];
				end
				default: begin
					bank1[1] <= lane[0];
					bank0[1] <= lane[1];
					bank1[0] <= lane[2];
					bank0[0] <= lane[3];
				end
			endcase
		end
	end

	// bank pair complete every second beat
	always_ff @(posedge clk) begin
		if (!beat_cnt[0]) begin
			latch0 <= bank0_flat;
			latch1 <= bank1_flat;
		end
	end

	// bank0 first, then bank1
	always_ff @(posedge clk) begin
		dout <= cnt_dly2 ? latch1 : latch0;
	end

	assign o_pix_data = dout;

	// valid levels follow the data by four stages
	always_ff @(posedge clk) begin
		if (i_reset) begin
			fval_sr <= '0;
			lval_sr <= '0;
		end else begin
			fval_sr <= {fval_sr[2:0], i_fval};
			lval_sr <= {lval_sr[2:0], i_lval};
		end
	end

	assign o_fval = fval_sr[3];
	assign o_lval = lval_sr[3];

endmodule

// File: logic/line_framer.sv
/*
 * line framer, tags beats with start-of-frame and end-of-line
 * one beat held so the end of line is known on release
 */
`timescale 1ns/1ns

module line_framer (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_fval,
	input  logic                         i_lval,
	input  logic [pix_pkg::BEAT_W-1:0]   i_pix_data,
	output logic                         o_wr,
	output logic [pix_pkg::BEAT_W-1:0]   o_data,
	output logic                         o_sof,
	output logic                         o_eol
);

	pix_pkg::framer_state_t      state;
	pix_pkg::framer_state_t      state_nxt;
	logic                        beat_valid;
	logic                        sof_arm;
	logic                        hold_valid;
	logic [pix_pkg::BEAT_W-1:0]  hold_data;

	assign beat_valid = i_fval & i_lval;

	// ------------------------------
	// frame / line tracking
	// ------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			pix_pkg::FR_IDLE: begin
				if (beat_valid) state_nxt = pix_pkg::FR_LINE;
				else if (i_fval) state_nxt = pix_pkg::FR_GAP;
			end
			pix_pkg::FR_LINE: begin
				if (!i_fval) state_nxt = pix_pkg::FR_IDLE;
				else if (!i_lval) state_nxt = pix_pkg::FR_GAP;
			end
			pix_pkg::FR_GAP: begin
				if (!i_fval) state_nxt = pix_pkg::FR_IDLE;
				else if (i_lval) state_nxt = pix_pkg::FR_LINE;
			end
			default: state_nxt = pix_pkg::FR_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state      <= pix_pkg::FR_IDLE;
			sof_arm    <= 1'b0;
			hold_valid <= 1'b0;
			o_wr       <= 1'b0;
			o_sof      <= 1'b0;
			o_eol      <= 1'b0;
		end else begin
			state      <= state_nxt;
			hold_valid <= beat_valid;
			// held beat always leaves one cycle later
			o_wr       <= hold_valid;
			o_sof      <= hold_valid & sof_arm;
			// no follow-on beat, so the held one closes the line
			o_eol      <= hold_valid & ~beat_valid;
			// armed on frame start, spent by the first release
			if (state == pix_pkg::FR_IDLE && i_fval) sof_arm <= 1'b1;
			else if (hold_valid) sof_arm <= 1'b0;
		end
	end

	// payload path
	always_ff @(posedge clk) begin
		if (beat_valid) hold_data <= i_pix_data;
		if (hold_valid) o_data <= hold_data;
	end

endmodule

// File: logic/credit_out_buffer.sv
/*
 * credit-based output buffer
 * beat FIFO with tags, credit counter and sticky overflow flag
 */
`timescale 1ns/1ns

module credit_out_buffer (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_wr,
	input  logic [pix_pkg::BEAT_W-1:0]   i_data,
	input  logic                         i_sof,
	input  logic                         i_eol,
	input  logic                         i_credit,
	output logic                         o_valid,
	output logic [pix_pkg::BEAT_W-1:0]   o_data,
	output logic                         o_sof,
	output logic                         o_eol,
	output logic                         o_overflow
);

	// entry layout: {sof, eol, data}
	logic [pix_pkg::BEAT_W+1:0]      fifo_mem [pix_pkg::FIFO_DEPTH];
	logic [pix_pkg::BEAT_W+1:0]      rd_entry;
	logic [pix_pkg::FIFO_AW-1:0]     wr_ptr;
	logic [pix_pkg::FIFO_AW-1:0]     rd_ptr;
	logic [pix_pkg::FIFO_AW:0]       fifo_cnt;
	logic [pix_pkg::CREDIT_W-1:0]    credit_cnt;
	logic                            fifo_empty;
	logic                            fifo_full;
	logic                            pop;
	logic                            push;

	assign fifo_empty = (fifo_cnt == '0);
	assign fifo_full  = (fifo_cnt == pix_pkg::FIFO_DEPTH);

	// send whenever a beat waits and the receiver has room
	assign pop  = ~fifo_empty & (credit_cnt != '0);
	// a pop in the same cycle frees the slot
	assign push = i_wr & (~fifo_full | pop);

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge clk) begin
		if (push) fifo_mem[wr_ptr] <= {i_sof, i_eol, i_data};
	end

	// first word fall-through read
	assign rd_entry   = fifo_mem[rd_ptr];
	assign o_valid    = pop;
	assign o_data     = rd_entry[pix_pkg::BEAT_W-1:0];
	assign o_eol      = pop & rd_entry[pix_pkg::BEAT_W];
	assign o_sof      = pop & rd_entry[pix_pkg::BEAT_W+1];

	// pointers and fill level
	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
				2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
				default: fifo_cnt <= fifo_cnt;
			endcase
		end
	end

	// ------------------------------
	// credits and overflow
	// ------------------------------
	// pulse and send together cancel out
	always_ff @(posedge clk) begin
		if (i_reset) begin
			credit_cnt <= pix_pkg::CREDIT_W'(pix_pkg::CREDIT_MAX);
		end else begin
			case ({i_credit, pop})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// sticky until reset, sensor side cannot be held off
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_overflow <= 1'b0;
		end else if (i_wr && !push) begin
			o_overflow <= 1'b1;
		end
	end

endmodule

// File: logic/sensor_reorder_top.sv
/*
 * sensor reorder subsystem top
 * kernel reorder, line framer and credit output buffer in a chain
 */
`timescale 1ns/1ns

module sensor_reorder_top (
	input  logic                         clk,
	input  logic                         i_reset,
	input  logic                         i_fval,
	input  logic                         i_lval,
	input  logic [pix_pkg::BEAT_W-1:0]   i_pix_data,
	input  logic                         i_credit,
	output logic                         o_valid,
	output logic [pix_pkg::BEAT_W-1:0]   o_data,
	output logic                         o_sof,
	output logic                         o_eol,
	output logic                         o_overflow
);

	// reorder to framer
	logic                        ro_fval;
	logic                        ro_lval;
	logic [pix_pkg::BEAT_W-1:0]  ro_data;
	// framer to buffer
	logic                        fr_wr;
	logic [pix_pkg::BEAT_W-1:0]  fr_data;
	logic                        fr_sof;
	logic                        fr_eol;

	kernel_reorder i_kernel_reorder (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_fval     (i_fval),
		.i_lval     (i_lval),
		.i_pix_data (i_pix_data),
		.o_fval     (ro_fval),
		.o_lval     (ro_lval),
		.o_pix_data (ro_data)
	);

	line_framer i_line_framer (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_fval     (ro_fval),
		.i_lval     (ro_lval),
		.i_pix_data (ro_data),
		.o_wr       (fr_wr),
		.o_data     (fr_data),
		.o_sof      (fr_sof),
		.o_eol      (fr_eol)
	);

	credit_out_buffer i_credit_out_buffer (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_wr       (fr_wr),
		.i_data     (fr_data),
		.i_sof      (fr_sof),
		.i_eol      (fr_eol),
		.i_credit   (i_credit),
		.o_valid    (o_valid),
		.o_data     (o_data),
		.o_sof      (o_sof),
		.o_eol      (o_eol),
		.o_overflow (o_overflow)
	);

endmodule

// File: sim/tb_reorder_model.svh
/*
 * reference model for the sensor reorder path
 * kernel reorder rule, beat tags, expected beats as {sof, eol, data}
 */

// one pixel out of a sensor beat, lane 0 lowest
function automatic logic [pix_pkg::PIX_W-1:0] chan(
	input logic [pix_pkg::BEAT_W-1:0] b,
	input int c
);
	return b[c*pix_pkg::PIX_W +: pix_pkg::PIX_W];
endfunction

// linear output beat idx of the current line
// concatenation is lane 3 first
function automatic logic [pix_pkg::BEAT_W-1:0] reorder_beat(input int idx);
	logic [pix_pkg::BEAT_W-1:0] b0;
	logic [pix_pkg::BEAT_W-1:0] b1;
	logic [pix_pkg::BEAT_W-1:0] b2;
	logic [pix_pkg::BEAT_W-1:0] b3;
	int base;
	base = idx - (idx % pix_pkg::GROUP_BEATS);
	b0 = line_beats[base];
	b1 = line_beats[base + 1];
	b2 = line_beats[base + 2];
	b3 = line_beats[base + 3];
	case (idx % pix_pkg::GROUP_BEATS)
		0: return {chan(b1, 2), chan(b1, 0), chan(b0, 2), chan(b0, 0)};
		1: return {chan(b1, 3), chan(b1, 1), chan(b0, 3), chan(b0, 1)};
		// second kernel comes in mirrored
		2: return {chan(b2, 1), chan(b2, 3), chan(b3, 1), chan(b3, 3)};
		default: return {chan(b2, 0), chan(b2, 2), chan(b3, 0), chan(b3, 2)};
	endcase
endfunction

// sof on the first beat of a frame, eol on the last of every line
function automatic void push_expected(input int len, input bit first_line);
	logic sof;
	logic eol;
	for (int k = 0; k < len; k++) begin
		sof = first_line && (k == 0);
		eol = (k == len - 1);
		exp_q.push_back({sof, eol, reorder_beat(k)});
	end
endfunction

// File: sim/tb_sensor_reorder.sv
/*
 * testbench for the sensor reorder subsystem
 * sensor stimulus, credit return, compare process and final report
 */
`timescale 1ns/1ns

module tb_sensor_reorder;

	logic                         clk;
	logic                         i_reset;
	logic                         i_fval;
	logic                         i_lval;
	logic [pix_pkg::BEAT_W-1:0]   i_pix_data;
	logic                         i_credit;
	logic                         o_valid;
	logic [pix_pkg::BEAT_W-1:0]   o_data;
	logic                         o_sof;
	logic                         o_eol;
	logic                         o_overflow;

	// current line as sent, expected beats {sof, eol, data}
	logic [pix_pkg::BEAT_W-1:0]   line_beats [0:63];
	logic [pix_pkg::BEAT_W+1:0]   exp_q [$];
	logic [pix_pkg::BEAT_W+1:0]   exp_entry;
	integer                       seed;
	bit                           credit_on;
	// beats sent but not yet credited back
	int                           owed;
	int                           sends_since_credit;
	int                           delivered;
	int                           start;
	int                           data_errs;
	int                           tag_errs;
	int                           other_errs;

	`include "tb_reorder_model.svh"

	sensor_reorder_top i_sensor_reorder_top (
		.clk        (clk),
		.i_reset    (i_reset),
		.i_fval     (i_fval),
		.i_lval     (i_lval),
		.i_pix_data (i_pix_data),
		.i_credit   (i_credit),
		.o_valid    (o_valid),
		.o_data     (o_data),
		.o_sof      (o_sof),
		.o_eol      (o_eol),
		.o_overflow (o_overflow)
	);

	always #5 clk = ~clk;

	// ------------------------------
	// credit return and compare
	// ------------------------------
	// one credit per cycle while owed and enabled
	always @(posedge clk) begin
		#1;
		if (credit_on && owed > 0) begin
			i_credit = 1'b1;
			owed--;
		end else begin
			i_credit = 1'b0;
		end
	end

	always @(negedge clk) begin
		if (i_reset) begin
			owed = 0;
			sends_since_credit = 0;
		end else begin
			if (i_credit) sends_since_credit = 0;
			if (o_valid === 1'b1) begin
				delivered++;
				owed++;
				sends_since_credit++;
				assert (sends_since_credit <= pix_pkg::CREDIT_MAX) else begin
					$display("o_valid high with all credits used at %0t", $time);
					other_errs++;
				end
				assert (exp_q.size() > 0) else begin
					$display("beat delivered with none expected at %0t", $time);
					other_errs++;
				end
				if (exp_q.size() > 0) begin
					exp_entry = exp_q.pop_front();
					check_beat(exp_entry);
				end
			end
		end
	end

	task automatic check_beat(input logic [pix_pkg::BEAT_W+1:0] want);
		assert (o_data === want[pix_pkg::BEAT_W-1:0]) else begin
			$display("Fail %0t o_data expected %h actual %h",
				$time, want[pix_pkg::BEAT_W-1:0], o_data);
			data_errs++;
		end
		assert (o_sof === want[pix_pkg::BEAT_W+1]) else begin
			$display("Fail %0t o_sof expected %b actual %b",
				$time, want[pix_pkg::BEAT_W+1], o_sof);
			tag_errs++;
		end
		assert (o_eol === want[pix_pkg::BEAT_W]) else begin
			$display("Fail %0t o_eol expected %b actual %b",
				$time, want[pix_pkg::BEAT_W], o_eol);
			tag_errs++;
		end
	endtask

	task automatic check_level(input string name, input logic act, input logic want);
		assert (act === want) else begin
			$display("Fail %0t %s expected %b actual %b", $time, name, want, act);
			other_errs++;
		end
	endtask

	task automatic check_reset_outputs();
		@(negedge clk);
		check_level("o_valid", o_valid, 1'b0);
		check_level("o_sof", o_sof, 1'b0);
		check_level("o_eol", o_eol, 1'b0);
		check_level("o_overflow", o_overflow, 1'b0);
	endtask

	// ------------------------------
	// stimulus
	// ------------------------------
	task automatic apply_reset();
		@(posedge clk);
		#1;
		i_reset = 1'b1;
		i_fval = 1'b0;
		i_lval = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		i_reset = 1'b0;
	endtask

	// random pixels, expected beats queued before the line goes out
	task automatic send_line(input int len, input bit first_line);
		logic [63:0] rnd;
		for (int k = 0; k < len; k++) begin
			rnd = {$random(seed), $random(seed)};
			line_beats[k] = rnd[pix_pkg::BEAT_W-1:0];
		end
		push_expected(len, first_line);
		for (int k = 0; k < len; k++) begin
			@(posedge clk);
			#1;
			i_lval = 1'b1;
			i_pix_data = line_beats[k];
		end
	endtask

	// fval rises one cycle ahead, gap grows by a cycle per line
	task automatic send_frame(input int lines, input int len, input int gap);
		@(posedge clk);
		#1;
		i_fval = 1'b1;
		for (int l = 0; l < lines; l++) begin
			send_line(len, l == 0);
			repeat (gap + l) begin
				@(posedge clk);
				#1;
				i_lval = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		i_fval = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	// ------------------------------
	// waits and report
	// ------------------------------
	task automatic report_and_finish();
		$display("data errors %0d, tag errors %0d, other errors %0d",
			data_errs, tag_errs, other_errs);
		if (data_errs + tag_errs + other_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s at %0t", what, $time);
		other_errs++;
		report_and_finish();
	endtask

	// all expected beats out and all credits back
	task automatic wait_drained(input string what);
		int n;
		n = 0;
		while ((exp_q.size() != 0 || owed != 0) && n < 500) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0 || owed != 0) abort_on_timeout(what);
	endtask

	task automatic wait_delivered(input int target);
		int n;
		n = 0;
		while (delivered < target && n < 300) begin
			@(negedge clk);
			n++;
		end
		if (delivered < target) abort_on_timeout("beats sent on initial credits");
	endtask

	task automatic wait_overflow();
		int n;
		n = 0;
		while (o_overflow !== 1'b1 && n < 300) begin
			@(negedge clk);
			n++;
		end
		if (o_overflow !== 1'b1) abort_on_timeout("o_overflow");
	endtask

	initial begin
		seed = 32'hf16a;
		clk = 1'b0;
		i_reset = 1'b1;
		i_fval = 1'b0;
		i_lval = 1'b0;
		i_pix_data = '0;
		i_credit = 1'b0;
		credit_on = 1'b1;
		owed = 0;
		sends_since_credit = 0;
		delivered = 0;
		data_errs = 0;
		tag_errs = 0;
		other_errs = 0;
		apply_reset();
		check_reset_outputs();

		// reorder, three lines of two groups each
		send_frame(3, 8, 2);
		wait_drained("reorder frame");

		// tags over two frames, short and long lines
		send_frame(3, 4, 2);
		send_frame(2, 12, 3);
		wait_drained("tag frames");

		// credit limit, FIFO absorbs the rest of the line
		credit_on = 1'b0;
		start = delivered;
		send_frame(1, 20, 2);
		wait_delivered(start + pix_pkg::CREDIT_MAX);
		repeat (30) @(negedge clk);
		assert (delivered == start + pix_pkg::CREDIT_MAX) else begin
			$display("beats sent beyond the granted credits");
			other_errs++;
		end
		credit_on = 1'b1;
		wait_drained("beats after credit return");
		check_level("o_overflow", o_overflow, 1'b0);

		// overflow, line longer than credits plus FIFO
		credit_on = 1'b0;
		start = delivered;
		send_frame(1, 32, 2);
		wait_delivered(start + pix_pkg::CREDIT_MAX);
		wait_overflow();
		repeat (20) begin
			@(negedge clk);
			check_level("o_overflow", o_overflow, 1'b1);
		end
		assert (delivered == start + pix_pkg::CREDIT_MAX) else begin
			$display("beats delivered without credit during overflow");
			other_errs++;
		end

		// dropped beats never arrive, reset flushes the FIFO
		exp_q.delete();
		apply_reset();
		credit_on = 1'b1;
		check_reset_outputs();
		send_frame(2, 8, 2);
		wait_drained("frame after reset");
		report_and_finish();
	end

endmodule

// File: tb.f
+incdir+sim
logic/pix_pkg.sv
logic/kernel_reorder.sv
logic/line_framer.sv
logic/credit_out_buffer.sv
logic/sensor_reorder_top.sv
sim/tb_sensor_reorder.sv

// File: Bender.yml
package:
  name: sensor_reorder

sources:
  # RTL, package first
  - files:
      - logic/pix_pkg.sv
      - logic/kernel_reorder.sv
      - logic/line_framer.sv
      - logic/credit_out_buffer.sv
      - logic/sensor_reorder_top.sv

  # testbench, model header included from sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_sensor_reorder.sv
